//--- source/avmm_pkg.sv
package avmm_pkg;

    // Avalon-MM read side with one 512-bit beat per transfer
    localparam int BEAT_BYTES     = 64;
    localparam int WORDS_PER_BEAT = 16;

    typedef logic [63:0]  avmm_addr_t;   // byte address
    typedef logic [511:0] avmm_beat_t;
    typedef logic [63:0]  avmm_be_t;
    typedef logic [2:0]   avmm_burst_t;

endpackage

//--- source/loader_pkg.sv
package loader_pkg;

    localparam int CORES      = 4;
    localparam int INSN_WORDS = 64;    // per core
    localparam int DATA_WORDS = 128;   // per core
    localparam int INSN_BEATS = 4;
    localparam int DATA_BEATS = 8;

    typedef logic [1:0]  core_id_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0]  insn_index_t;
    typedef logic [6:0]  data_index_t;

    typedef enum logic [2:0] {
        IDLE,
        INSN_REQ,
        INSN_WAIT,
        INSN_WRITE,
        DATA_REQ,
        DATA_WAIT,
        DATA_WRITE
    } load_state_t;

endpackage

//--- source/avmm_read_master.sv
`timescale 1ns/1ns

module avmm_read_master (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   beat_req,
    input  avmm_pkg::avmm_addr_t   beat_addr,
    output logic                   beat_valid,
    output avmm_pkg::avmm_beat_t   beat_data,

    input  logic                   m0_waitrequest,
    input  logic                   m0_readdatavalid,
    input  avmm_pkg::avmm_beat_t   m0_readdata,
    output avmm_pkg::avmm_addr_t   m0_address,
    output logic                   m0_read,
    output avmm_pkg::avmm_burst_t  m0_burstcount,
    output avmm_pkg::avmm_be_t     m0_byteenable
);
    import avmm_pkg::*;

    // single beats with every byte enabled
    assign m0_burstcount = avmm_burst_t'(1);
    assign m0_byteenable = '1;

    always_ff @(posedge clk) begin
        if (reset) begin
            m0_read    <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            if (beat_req) begin
                m0_read <= 1'b1;
            end else if (m0_read && !m0_waitrequest) begin
                m0_read <= 1'b0;   // accepted by slave
            end
            beat_valid <= m0_readdatavalid;
        end
    end

    // address held steady while waitrequest stalls the read
    always_ff @(posedge clk) begin
        if (beat_req) begin
            m0_address <= beat_addr;
        end
        if (m0_readdatavalid) begin
            beat_data <= m0_readdata;
        end
    end

endmodule

//--- source/load_sequencer.sv
`timescale 1ns/1ns

module load_sequencer (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    kick,
    output logic                    busy,
    input  avmm_pkg::avmm_addr_t    memory_base_addr,
    input  loader_pkg::core_id_t    target_core,

    output logic                    beat_req,
    output avmm_pkg::avmm_addr_t    beat_addr,
    input  logic                    beat_valid,
    input  avmm_pkg::avmm_beat_t    beat_data,

    output loader_pkg::core_id_t    wr_core,
    output logic                    insn_we,
    output loader_pkg::insn_index_t insn_wr_index,
    output logic                    data_we,
    output loader_pkg::data_index_t data_wr_index,
    output loader_pkg::word_t       wr_word
);
    import avmm_pkg::*;
    import loader_pkg::*;

    load_state_t state;
    logic        busy_q;
    logic [3:0]  beat_cnt;
    insn_index_t insn_cnt;
    data_index_t data_cnt;
    avmm_addr_t  base_q;
    avmm_beat_t  beat_sr;    // unpacked low word first

    logic        accept;
    logic        writing;
    logic [3:0]  word_pos;
    logic        beat_done;

    assign accept    = (state == IDLE) && kick && !busy_q;
    assign writing   = (state == INSN_WRITE) || (state == DATA_WRITE);
    assign word_pos  = (state == DATA_WRITE) ? data_cnt[3:0] : insn_cnt[3:0];
    assign beat_done = word_pos == 4'(WORDS_PER_BEAT - 1);

    assign busy      = busy_q | kick;
    assign beat_req  = (state == INSN_REQ) || (state == DATA_REQ);
    assign beat_addr = base_q + avmm_addr_t'(beat_cnt) * avmm_addr_t'(BEAT_BYTES);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            busy_q   <= 1'b0;
            beat_cnt <= '0;
            insn_cnt <= '0;
            data_cnt <= '0;
            insn_we  <= 1'b0;
            data_we  <= 1'b0;
        end else begin
            insn_we <= 1'b0;
            data_we <= 1'b0;
            case (state)
                IDLE: begin
                    busy_q <= accept;   // drops one cycle after the last write
                    if (accept) begin
                        beat_cnt <= '0;
                        insn_cnt <= '0;
                        data_cnt <= '0;
                        state    <= INSN_REQ;
                    end
                end
                INSN_REQ: state <= INSN_WAIT;
                INSN_WAIT: begin
                    if (beat_valid) begin
                        state <= INSN_WRITE;
                    end
                end
                INSN_WRITE: begin
                    insn_we  <= 1'b1;
                    insn_cnt <= insn_cnt + 1'b1;
                    if (beat_done) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == 4'(INSN_BEATS - 1)) begin
                            state <= DATA_REQ;
                        end else begin
                            state <= INSN_REQ;
                        end
                    end
                end
                DATA_REQ: state <= DATA_WAIT;
                DATA_WAIT: begin
                    if (beat_valid) begin
                        state <= DATA_WRITE;
                    end
                end
                DATA_WRITE: begin
                    data_we  <= 1'b1;
                    data_cnt <= data_cnt + 1'b1;
                    if (beat_done) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == 4'(INSN_BEATS + DATA_BEATS - 1)) begin
                            state <= IDLE;   // end of image
                        end else begin
                            state <= DATA_REQ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            base_q  <= memory_base_addr;
            wr_core <= target_core;
        end
        if (beat_valid && ((state == INSN_WAIT) || (state == DATA_WAIT))) begin
            beat_sr <= beat_data;
        end else if (writing) begin
            beat_sr <= beat_sr >> $bits(word_t);
        end
        wr_word       <= beat_sr[$bits(word_t)-1:0];
        insn_wr_index <= insn_cnt;
        data_wr_index <= data_cnt;
    end

endmodule

//--- source/core_mem_bank.sv
`timescale 1ns/1ns

module core_mem_bank (
    input  logic                    clk,

    // write side from the sequencer
    input  loader_pkg::core_id_t    wr_core,
    input  logic                    insn_we,
    input  loader_pkg::insn_index_t insn_wr_index,
    input  logic                    data_we,
    input  loader_pkg::data_index_t data_wr_index,
    input  loader_pkg::word_t       wr_word,

    // core fetch port
    input  loader_pkg::core_id_t    rd_core,
    input  loader_pkg::insn_index_t insn_rd_addr,
    output loader_pkg::word_t       insn_rd_data,
    input  loader_pkg::data_index_t data_rd_addr,
    output loader_pkg::word_t       data_rd_data
);
    import loader_pkg::*;

    word_t insn_mem [CORES][INSN_WORDS];
    word_t data_mem [CORES][DATA_WORDS];

    always_ff @(posedge clk) begin
        if (insn_we) begin
            insn_mem[wr_core][insn_wr_index] <= wr_word;
        end
        insn_rd_data <= insn_mem[rd_core][insn_rd_addr];   // registered read
    end

    always_ff @(posedge clk) begin
        if (data_we) begin
            data_mem[wr_core][data_wr_index] <= wr_word;
        end
        data_rd_data <= data_mem[rd_core][data_rd_addr];
    end

endmodule

//--- source/program_loader.sv
`timescale 1ns/1ns

module program_loader (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    kick,
    output logic                    busy,
    input  avmm_pkg::avmm_addr_t    memory_base_addr,
    input  loader_pkg::core_id_t    target_core,

    input  logic                    m0_waitrequest,
    input  avmm_pkg::avmm_beat_t    m0_readdata,
    input  logic                    m0_readdatavalid,
    output avmm_pkg::avmm_burst_t   m0_burstcount,
    output avmm_pkg::avmm_addr_t    m0_address,
    output logic                    m0_read,
    output avmm_pkg::avmm_be_t      m0_byteenable,

    input  loader_pkg::core_id_t    rd_core,
    input  loader_pkg::insn_index_t insn_rd_addr,
    output loader_pkg::word_t       insn_rd_data,
    input  loader_pkg::data_index_t data_rd_addr,
    output loader_pkg::word_t       data_rd_data
);
    import avmm_pkg::*;
    import loader_pkg::*;

    logic        beat_req;
    avmm_addr_t  beat_addr;
    logic        beat_valid;
    avmm_beat_t  beat_data;

    core_id_t    wr_core;
    logic        insn_we;
    insn_index_t insn_wr_index;
    logic        data_we;
    data_index_t data_wr_index;
    word_t       wr_word;

    avmm_read_master master_i (
        .clk              (clk),
        .reset            (reset),
        .beat_req         (beat_req),
        .beat_addr        (beat_addr),
        .beat_valid       (beat_valid),
        .beat_data        (beat_data),
        .m0_waitrequest   (m0_waitrequest),
        .m0_readdatavalid (m0_readdatavalid),
        .m0_readdata      (m0_readdata),
        .m0_address       (m0_address),
        .m0_read          (m0_read),
        .m0_burstcount    (m0_burstcount),
        .m0_byteenable    (m0_byteenable)
    );

    load_sequencer sequencer_i (
        .clk              (clk),
        .reset            (reset),
        .kick             (kick),
        .busy             (busy),
        .memory_base_addr (memory_base_addr),
        .target_core      (target_core),
        .beat_req         (beat_req),
        .beat_addr        (beat_addr),
        .beat_valid       (beat_valid),
        .beat_data        (beat_data),
        .wr_core          (wr_core),
        .insn_we          (insn_we),
        .insn_wr_index    (insn_wr_index),
        .data_we          (data_we),
        .data_wr_index    (data_wr_index),
        .wr_word          (wr_word)
    );

    core_mem_bank mem_i (
        .clk              (clk),
        .wr_core          (wr_core),
        .insn_we          (insn_we),
        .insn_wr_index    (insn_wr_index),
        .data_we          (data_we),
        .data_wr_index    (data_wr_index),
        .wr_word          (wr_word),
        .rd_core          (rd_core),
        .insn_rd_addr     (insn_rd_addr),
        .insn_rd_data     (insn_rd_data),
        .data_rd_addr     (data_rd_addr),
        .data_rd_data     (data_rd_data)
    );

endmodule

//--- tests/avmm_mem_model.sv
`timescale 1ns/1ns

module avmm_mem_model (
    input  logic                 clk,
    input  logic                 reset,
    input  avmm_pkg::avmm_addr_t address,
    input  logic                 read,
    output logic                 waitrequest,
    output avmm_pkg::avmm_beat_t readdata,
    output logic                 readdatavalid
);
    import avmm_pkg::*;

    localparam int IMAGE_BEATS = 2048;

    avmm_beat_t  image [IMAGE_BEATS];
    integer      seed;
    logic        pending;
    int          delay;
    logic [10:0] beat_sel;

    initial begin
        seed = 61359;
        for (int b = 0; b < IMAGE_BEATS; b++) begin
            for (int w = 0; w < WORDS_PER_BEAT; w++) begin
                image[b][32*w +: 32] = $random(seed);
            end
        end
        waitrequest   = 1'b1;
        readdatavalid = 1'b0;
        readdata      = '0;
        pending       = 1'b0;
        delay         = 0;
        beat_sel      = '0;
    end

    always @(posedge clk) begin
        readdatavalid <= 1'b0;
        if (reset) begin
            pending     <= 1'b0;
            waitrequest <= 1'b1;
        end else begin
            waitrequest <= ($random(seed) & 3) < 2;   // stalls about half the cycles
            if (read && !waitrequest && !pending) begin
                pending  <= 1'b1;
                delay    <= 1 + $unsigned($random(seed)) % 6;
                beat_sel <= address[16:6];   // beat index wrapping at the image size
            end else if (pending) begin
                if (delay == 1) begin
                    pending       <= 1'b0;
                    readdatavalid <= 1'b1;
                    readdata      <= image[beat_sel];
                end
                delay <= delay - 1;
            end
        end
    end

endmodule

//--- tests/program_loader_tb.sv
`timescale 1ns/1ns

module program_loader_tb;
    import avmm_pkg::*;
    import loader_pkg::*;

    localparam int CYCLE_LIMIT = 6000;
    localparam int MAX_BEAT    = 2048 - INSN_BEATS - DATA_BEATS;

    logic clk = 1'b0;
    logic reset, kick, busy, m0_waitrequest, m0_readdatavalid, m0_read;
    avmm_addr_t  memory_base_addr, m0_address;
    core_id_t    target_core, rd_core;
    avmm_beat_t  m0_readdata;
    avmm_burst_t m0_burstcount;
    avmm_be_t    m0_byteenable;
    insn_index_t insn_rd_addr;
    data_index_t data_rd_addr;
    word_t       insn_rd_data, data_rd_data;

    word_t      insn_model [CORES][INSN_WORDS];
    word_t      data_model [CORES][DATA_WORDS];
    integer     seed;
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         cycle_cnt = 0;
    int         stall_hits = 0;
    int         errs_before, hits_before;
    logic       stall_prev = 1'b0;
    avmm_addr_t addr_prev;

    program_loader dut_i (
        .clk(clk), .reset(reset), .kick(kick), .busy(busy),
        .memory_base_addr(memory_base_addr), .target_core(target_core),
        .m0_waitrequest(m0_waitrequest), .m0_readdata(m0_readdata),
        .m0_readdatavalid(m0_readdatavalid), .m0_burstcount(m0_burstcount),
        .m0_address(m0_address), .m0_read(m0_read), .m0_byteenable(m0_byteenable),
        .rd_core(rd_core), .insn_rd_addr(insn_rd_addr), .insn_rd_data(insn_rd_data),
        .data_rd_addr(data_rd_addr), .data_rd_data(data_rd_data)
    );

    avmm_mem_model model_i (
        .clk(clk), .reset(reset), .address(m0_address), .read(m0_read),
        .waitrequest(m0_waitrequest), .readdata(m0_readdata),
        .readdatavalid(m0_readdatavalid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timed out: no result after %0d clock cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // a stalled read must hold its address into the next cycle
    always @(negedge clk) begin
        if (stall_prev) begin
            stall_hits++;
            if (!m0_read || m0_address !== addr_prev) begin
                errors++;
                $display("error at %0t: read changed under waitrequest, addr %h was %h",
                         $time, m0_address, addr_prev);
            end
        end
        stall_prev = m0_read && m0_waitrequest && !reset;
        addr_prev  = m0_address;
    end

    function automatic int random_beat();
        return $unsigned($random(seed)) % MAX_BEAT;
    endfunction

    task automatic update_model(input core_id_t c, input int beat);
        avmm_beat_t b;
        for (int i = 0; i < INSN_WORDS; i++) begin
            b = model_i.image[beat + i / WORDS_PER_BEAT];
            insn_model[c][i] = b[32*(i % WORDS_PER_BEAT) +: 32];
        end
        for (int j = 0; j < DATA_WORDS; j++) begin
            b = model_i.image[beat + INSN_BEATS + j / WORDS_PER_BEAT];
            data_model[c][j] = b[32*(j % WORDS_PER_BEAT) +: 32];
        end
    endtask

    task automatic run_load(input core_id_t c, input int beat, input bit kick_again);
        int cycles;
        cycles = 0;
        @(posedge clk);
        kick             <= 1'b1;
        memory_base_addr <= avmm_addr_t'(beat * BEAT_BYTES);
        target_core      <= c;
        update_model(c, beat);
        @(negedge clk);
        if (busy !== 1'b1) begin
            errors++;
            $display("error at %0t: busy low in the kick cycle", $time);
        end
        do begin
            @(posedge clk);
            kick <= kick_again && cycles == 40;   // second kick in mid load
            if (kick_again && cycles == 40) begin
                target_core      <= c + 2'd1;
                memory_base_addr <= avmm_addr_t'(random_beat() * BEAT_BYTES);
            end
            @(negedge clk);
            cycles++;
        end while (busy);
        if (cycles < (INSN_BEATS + DATA_BEATS) * WORDS_PER_BEAT) begin
            errors++;
            $display("error at %0t: busy only %0d cycles", $time, cycles);
        end
    endtask

    task automatic check_core(input core_id_t c);
        for (int i = 0; i <= DATA_WORDS; i++) begin
            @(posedge clk);
            rd_core      <= c;
            insn_rd_addr <= insn_index_t'(i);
            data_rd_addr <= data_index_t'(i);
            @(negedge clk);
            if (i > 0 && i <= INSN_WORDS && insn_rd_data !== insn_model[c][i-1]) begin
                errors++;
                $display("error at %0t: core %0d insn word %0d is %h, expected %h",
                         $time, c, i - 1, insn_rd_data, insn_model[c][i-1]);
            end
            if (i > 0 && data_rd_data !== data_model[c][i-1]) begin
                errors++;
                $display("error at %0t: core %0d data word %0d is %h, expected %h",
                         $time, c, i - 1, data_rd_data, data_model[c][i-1]);
            end
        end
    endtask

    task automatic check_all();
        for (int c = 0; c < CORES; c++) begin
            check_core(core_id_t'(c));
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_at_start);
        end
    endtask

    initial begin
        seed             = 61359;
        reset            = 1'b1;
        kick             = 1'b0;
        memory_base_addr = '0;
        target_core      = '0;
        rd_core          = '0;
        insn_rd_addr     = '0;
        data_rd_addr     = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        errs_before = errors;
        repeat (8) begin
            @(negedge clk);
            if (busy !== 1'b0 || m0_read !== 1'b0 ||
                m0_burstcount !== 3'd1 || m0_byteenable !== '1) begin
                errors++;
                $display("error at %0t: bus or busy not idle after reset", $time);
            end
        end
        end_test("idle after reset", errs_before);

        errs_before = errors;
        run_load(2'd0, random_beat(), 1'b0);
        check_all();
        end_test("load core 0", errs_before);

        errs_before = errors;
        for (int c = 1; c < CORES; c++) begin
            run_load(core_id_t'(c), random_beat(), 1'b0);
        end
        check_all();
        end_test("load cores 1 to 3", errs_before);

        errs_before = errors;
        hits_before = stall_hits;
        run_load(2'd2, random_beat(), 1'b0);
        check_all();
        if (stall_hits == hits_before) begin
            errors++;
            $display("no read was stalled by waitrequest during the load");
        end
        end_test("waitrequest and latency", errs_before);

        errs_before = errors;
        run_load(2'd3, random_beat(), 1'b1);
        check_all();
        end_test("kick while busy", errs_before);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/avmm_pkg.sv
source/loader_pkg.sv
source/avmm_read_master.sv
source/load_sequencer.sv
source/core_mem_bank.sv
source/program_loader.sv
tests/avmm_mem_model.sv
tests/program_loader_tb.sv

//--- Bender.yml
package:
  name: program_loader

sources:
  - files:
      - source/avmm_pkg.sv
      - source/loader_pkg.sv
      - source/avmm_read_master.sv
      - source/load_sequencer.sv
      - source/core_mem_bank.sv
      - source/program_loader.sv
  - target: test
    files:
      - tests/avmm_mem_model.sv
      - tests/program_loader_tb.sv
